// ==== src/wmem_pkg.sv ====
package wmem_pkg;

    // axi side widths
    localparam int data_width = 32;
    localparam int addr_width = 8;

    // byte addressing, two offset bits dropped
    localparam int word_addr_width = addr_width - 2;
    localparam int strb_width = data_width / 8;

    // one ram word, seen whole or as byte lanes
    typedef union packed {
        logic [data_width-1:0] word;
        logic [strb_width-1:0][7:0] lanes;
    } mem_word_u;

    // merged axi write, skid buffer to ram
    typedef struct packed {
        logic [word_addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } wr_req_s;

    // zero-fill write from the sweep counter
    typedef struct packed {
        logic [word_addr_width-1:0] addr;
        logic wen;
    } clr_req_s;

endpackage

// ==== src/clear_sweep_counter.sv ====
`timescale 1ns/1ps

module clear_sweep_counter #(
    parameter int addr_width = wmem_pkg::addr_width
) (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETn,
    output wmem_pkg::clr_req_s clr_req,
    output logic               sweep_busy
);

    localparam int word_addr_width = addr_width - 2;
    localparam logic [word_addr_width-1:0] last_addr = '1;

    logic [word_addr_width-1:0] sweep_addr;
    logic                       busy_q;

    // one zero word per cycle, starting at word 0
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            sweep_addr <= '0;
            busy_q     <= 1'b1;
        end else if (busy_q) begin
            sweep_addr <= sweep_addr + 1'b1;
            // last word written on this edge
            if (sweep_addr == last_addr) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign clr_req.addr = sweep_addr;
    assign clr_req.wen  = busy_q;
    assign sweep_busy   = busy_q;

endmodule

// ==== src/write_skid_buffer.sv ====
`timescale 1ns/1ps

module write_skid_buffer #(
    parameter int data_width = wmem_pkg::data_width,
    parameter int addr_width = wmem_pkg::addr_width
) (
    input  logic                    S_AXI_ACLK,
    input  logic [addr_width-1:0]   S_AXI_AWADDR,
    input  logic [data_width-1:0]   S_AXI_WDATA,
    input  logic [data_width/8-1:0] S_AXI_WSTRB,
    input  logic                    aw_hold,
    input  logic                    w_hold,
    input  logic                    aw_held,
    input  logic                    w_held,
    output wmem_pkg::wr_req_s       wr_req
);

    localparam int word_addr_width = addr_width - 2;
    localparam int strb_width = data_width / 8;

    // holding registers, payload only
    logic [word_addr_width-1:0] aw_addr_q;
    logic [data_width-1:0]      w_data_q;
    logic [strb_width-1:0]      w_strb_q;

    // early address parked until its data shows up
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hold) begin
            aw_addr_q <= S_AXI_AWADDR[addr_width-1:2];
        end
    end

    // early data beat, strobes travel with it
    always_ff @(posedge S_AXI_ACLK) begin
        if (w_hold) begin
            w_data_q <= S_AXI_WDATA;
            w_strb_q <= S_AXI_WSTRB;
        end
    end

    // held value wins, else take the beat on the bus
    always_comb begin
        if (aw_held) begin
            wr_req.addr = aw_addr_q;
        end else begin
            wr_req.addr = S_AXI_AWADDR[addr_width-1:2];
        end
        if (w_held) begin
            wr_req.data = w_data_q;
            wr_req.strb = w_strb_q;
        end else begin
            wr_req.data = S_AXI_WDATA;
            wr_req.strb = S_AXI_WSTRB;
        end
    end

endmodule

// ==== src/axi_write_fsm.sv ====
`timescale 1ns/1ps

module axi_write_fsm (
    input  logic S_AXI_ACLK,
    input  logic S_AXI_ARESETn,
    input  logic S_AXI_AWVALID,
    input  logic S_AXI_WVALID,
    input  logic S_AXI_BREADY,
    input  logic sweep_busy,
    output logic S_AXI_AWREADY,
    output logic S_AXI_WREADY,
    output logic S_AXI_BVALID,
    output logic aw_hold,
    output logic w_hold,
    output logic aw_held,
    output logic w_held,
    output logic wr_fire
);

    typedef enum logic [1:0] {
        st_sweep,
        st_open,
        st_resp
    } state_e;

    state_e state;

    logic aw_take;
    logic w_take;
    logic aw_avail;
    logic w_avail;
    logic resp_stall;

    // handshakes completing this cycle
    assign aw_take = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_take  = S_AXI_WVALID && S_AXI_WREADY;

    // either parked or on the bus right now
    assign aw_avail = aw_held || aw_take;
    assign w_avail  = w_held || w_take;

    // response out and master not taking it
    assign resp_stall = S_AXI_BVALID && !S_AXI_BREADY;

    // pair complete and the b channel can take one more
    assign wr_fire = aw_avail && w_avail && !resp_stall;

    // park whatever arrived but could not be written
    assign aw_hold = aw_take && !wr_fire;
    assign w_hold  = w_take && !wr_fire;

    // single slot per channel, closed while something sits in it
    assign S_AXI_AWREADY = (state != st_sweep) && !aw_held;
    assign S_AXI_WREADY  = (state != st_sweep) && !w_held;
    assign S_AXI_BVALID  = (state == st_resp);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            state <= st_sweep;
        end else begin
            case (state)
                st_sweep: begin
                    // ram cleared, open the channels
                    if (!sweep_busy) begin
                        state <= st_open;
                    end
                end
                st_open: begin
                    if (wr_fire) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    // back-to-back write keeps bvalid up
                    if (wr_fire) begin
                        state <= st_resp;
                    end else if (S_AXI_BREADY) begin
                        state <= st_open;
                    end
                end
                default: begin
                    state <= st_sweep;
                end
            endcase
        end
    end

    // slot flags, set on park and cleared when the write goes out
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else if (wr_fire) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            aw_held <= aw_held || aw_hold;
            w_held  <= w_held || w_hold;
        end
    end

endmodule

// ==== src/dual_clock_ram.sv ====
`timescale 1ns/1ps

module dual_clock_ram #(
    parameter int data_width = wmem_pkg::data_width,
    parameter int addr_width = wmem_pkg::addr_width
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    wr_fire,
    input  wmem_pkg::wr_req_s       wr_req,
    input  wmem_pkg::clr_req_s      clr_req,
    input  logic                    sweep_busy,
    input  logic                    rclk,
    input  logic                    ren,
    input  logic [addr_width-3:0]   raddr,
    output logic [data_width-1:0]   rout,
    output logic                    rvalid
);

    import wmem_pkg::*;

    localparam int word_addr_width = addr_width - 2;
    localparam int depth = 2 ** word_addr_width;
    localparam int lanes = data_width / 8;

    mem_word_u mem [depth];
    mem_word_u wr_word;

    // incoming data split into byte lanes
    assign wr_word.word = wr_req.data;

    // write port, axi clock
    always_ff @(posedge S_AXI_ACLK) begin
        if (sweep_busy) begin
            // clear pass owns the port
            if (clr_req.wen) begin
                mem[clr_req.addr] <= '0;
            end
        end else if (wr_fire) begin
            // only strobed lanes change
            for (int i = 0; i < lanes; i++) begin
                if (wr_req.strb[i]) begin
                    mem[wr_req.addr].lanes[i] <= wr_word.lanes[i];
                end
            end
        end
    end

    // read port, one rclk of latency
    always_ff @(posedge rclk) begin
        if (ren) begin
            rout <= mem[raddr].word;
        end
    end

    // valid tracks the request one edge later
    always_ff @(posedge rclk) begin
        rvalid <= ren;
    end

endmodule

// ==== src/s_axi_lite_async_wmem.sv ====
`timescale 1ns/1ps

module s_axi_lite_async_wmem #(
    parameter int data_width = wmem_pkg::data_width,
    parameter int addr_width = wmem_pkg::addr_width
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETn,
    // write address channel
    input  logic [addr_width-1:0]   S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    // write data channel
    input  logic [data_width-1:0]   S_AXI_WDATA,
    input  logic [data_width/8-1:0] S_AXI_WSTRB,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    // write response channel
    output logic [1:0]              S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,
    // pl read port, rclk domain
    input  logic                    rclk,
    input  logic                    ren,
    input  logic [addr_width-3:0]   raddr,
    output logic [data_width-1:0]   rout,
    output logic                    rvalid
);

    import wmem_pkg::*;

    clr_req_s clr_req;
    wr_req_s  wr_req;
    logic     sweep_busy;
    logic     aw_hold;
    logic     w_hold;
    logic     aw_held;
    logic     w_held;
    logic     wr_fire;

    // no error cases, every write is OKAY
    assign S_AXI_BRESP = 2'b00;

    // zero fill after reset
    clear_sweep_counter #(
        .addr_width(addr_width)
    ) i_clear_sweep_counter (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETn(S_AXI_ARESETn),
        .clr_req      (clr_req),
        .sweep_busy   (sweep_busy)
    );

    // address and data slots
    write_skid_buffer #(
        .data_width(data_width),
        .addr_width(addr_width)
    ) i_write_skid_buffer (
        .S_AXI_ACLK  (S_AXI_ACLK),
        .S_AXI_AWADDR(S_AXI_AWADDR),
        .S_AXI_WDATA (S_AXI_WDATA),
        .S_AXI_WSTRB (S_AXI_WSTRB),
        .aw_hold     (aw_hold),
        .w_hold      (w_hold),
        .aw_held     (aw_held),
        .w_held      (w_held),
        .wr_req      (wr_req)
    );

    // handshake control
    axi_write_fsm i_axi_write_fsm (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETn(S_AXI_ARESETn),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .sweep_busy   (sweep_busy),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BVALID (S_AXI_BVALID),
        .aw_hold      (aw_hold),
        .w_hold       (w_hold),
        .aw_held      (aw_held),
        .w_held       (w_held),
        .wr_fire      (wr_fire)
    );

    // storage, written on axi clock and read on rclk
    dual_clock_ram #(
        .data_width(data_width),
        .addr_width(addr_width)
    ) i_dual_clock_ram (
        .S_AXI_ACLK(S_AXI_ACLK),
        .wr_fire   (wr_fire),
        .wr_req    (wr_req),
        .clr_req   (clr_req),
        .sweep_busy(sweep_busy),
        .rclk      (rclk),
        .ren       (ren),
        .raddr     (raddr),
        .rout      (rout),
        .rvalid    (rvalid)
    );

endmodule

// ==== testbench/wmem_checker.sv ====
`timescale 1ns/1ps

module wmem_checker (
    input logic                              S_AXI_ACLK,
    input logic                              S_AXI_ARESETn,
    input logic [wmem_pkg::addr_width-1:0]   S_AXI_AWADDR,
    input logic                              S_AXI_AWVALID,
    input logic                              S_AXI_AWREADY,
    input logic [wmem_pkg::data_width-1:0]   S_AXI_WDATA,
    input logic [wmem_pkg::strb_width-1:0]   S_AXI_WSTRB,
    input logic                              S_AXI_WVALID,
    input logic                              S_AXI_WREADY,
    input logic [1:0]                        S_AXI_BRESP,
    input logic                              S_AXI_BVALID,
    input logic                              S_AXI_BREADY,
    input logic                              rclk,
    input logic                              ren,
    input logic [wmem_pkg::word_addr_width-1:0] raddr,
    input logic [wmem_pkg::data_width-1:0]   rout,
    input logic                              rvalid
);

    import wmem_pkg::*;

    localparam int words = 2 ** word_addr_width;
    // clear pass length, one word per cycle
    localparam int sweep_len = words;

    logic [data_width-1:0] model [words];
    logic [word_addr_width-1:0] aw_q [$];
    logic [strb_width+data_width-1:0] w_q [$];
    logic [word_addr_width-1:0] pair_addr;
    logic [strb_width+data_width-1:0] pair_beat;
    logic [word_addr_width-1:0] rd_addr = '0;
    logic rd_pending = 1'b0;
    logic stall_seen = 1'b0;
    int since_reset = 0;
    int stall_aw = 0;
    int stall_w = 0;
    int pass_count = 0;
    int err_count = 0;
    int pair_count = 0;
    int b_count = 0;

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    always @(posedge S_AXI_ACLK) begin
        // channels shut from the second reset edge through the clear pass
        // first reset edge still sees the old state, reset is synchronous
        if (since_reset <= sweep_len) begin
            check_bit("S_AXI_AWREADY", 1'b0, S_AXI_AWREADY);
            check_bit("S_AXI_WREADY", 1'b0, S_AXI_WREADY);
            check_bit("S_AXI_BVALID", 1'b0, S_AXI_BVALID);
        end else if (since_reset == sweep_len + 1) begin
            check_bit("S_AXI_AWREADY", 1'b1, S_AXI_AWREADY);
            check_bit("S_AXI_WREADY", 1'b1, S_AXI_WREADY);
        end
        if (!S_AXI_ARESETn) begin
            since_reset = 0;
            stall_seen = 1'b0;
            stall_aw = 0;
            stall_w = 0;
            aw_q.delete();
            w_q.delete();
            // ram comes out of the sweep all zero
            for (int i = 0; i < words; i++) begin
                model[i] = '0;
            end
        end
        if (S_AXI_ARESETn) begin
            if (since_reset <= sweep_len + 1) begin
                since_reset++;
            end
            // a stalled response must not vanish
            if (stall_seen && !S_AXI_BVALID) begin
                $display("BVALID dropped while BREADY was still low");
                err_count++;
            end
            if (S_AXI_BVALID && S_AXI_BRESP !== 2'b00) begin
                $display("ERR S_AXI_BRESP expected 0 actual %h", S_AXI_BRESP);
                err_count++;
            end
            if (S_AXI_AWVALID && S_AXI_AWREADY) begin
                aw_q.push_back(S_AXI_AWADDR[addr_width-1:2]);
                if (S_AXI_BVALID && !S_AXI_BREADY) stall_aw++;
            end
            if (S_AXI_WVALID && S_AXI_WREADY) begin
                w_q.push_back({S_AXI_WSTRB, S_AXI_WDATA});
                if (S_AXI_BVALID && !S_AXI_BREADY) stall_w++;
            end
            // one slot per channel while B is blocked
            if (stall_aw > 1 || stall_w > 1) begin
                $display("more than one address or data beat taken during a B stall");
                err_count++;
                stall_aw = 1;
                stall_w = 1;
            end
            // pair in arrival order, merge strobed bytes
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                pair_addr = aw_q.pop_front();
                pair_beat = w_q.pop_front();
                for (int i = 0; i < strb_width; i++) begin
                    if (pair_beat[data_width+i]) begin
                        model[pair_addr][8*i +: 8] = pair_beat[8*i +: 8];
                    end
                end
                pair_count++;
            end
            if (S_AXI_BVALID && S_AXI_BREADY) begin
                if (b_count >= pair_count) begin
                    $display("B handshake with no completed write behind it");
                    err_count++;
                end
                b_count++;
                stall_aw = 0;
                stall_w = 0;
            end
            stall_seen = S_AXI_BVALID && !S_AXI_BREADY;
        end
    end

    // read port, data due one rclk edge after ren
    always @(posedge rclk) begin
        if (rd_pending) begin
            check_bit("rvalid", 1'b1, rvalid);
            if (rout !== model[rd_addr]) begin
                $display("ERR rout word %h expected %h actual %h", rd_addr, model[rd_addr], rout);
                err_count++;
            end else begin
                pass_count++;
            end
        end else if (rvalid === 1'b1) begin
            // no read issued on the previous edge
            $display("ERR rvalid expected %h actual %h", 1'b0, rvalid);
            err_count++;
        end
        rd_pending = ren;
        rd_addr = raddr;
    end

endmodule

// ==== testbench/tb_wmem.sv ====
`timescale 1ns/1ps

module tb_wmem;

    import wmem_pkg::*;

    localparam int words = 2 ** word_addr_width;
    localparam int n_writes = 16;
    localparam int n_stall_writes = 8;
    // writes plus one full read sweep per test
    localparam int n_ops = 3 * n_writes + n_stall_writes + 6 * words;
    localparam int cycle_limit = n_ops * 12 + 200;

    logic S_AXI_ACLK = 1'b0;
    logic rclk = 1'b0;
    logic S_AXI_ARESETn;
    logic [addr_width-1:0] S_AXI_AWADDR;
    logic S_AXI_AWVALID;
    logic S_AXI_AWREADY;
    logic [data_width-1:0] S_AXI_WDATA;
    logic [strb_width-1:0] S_AXI_WSTRB;
    logic S_AXI_WVALID;
    logic S_AXI_WREADY;
    logic [1:0] S_AXI_BRESP;
    logic S_AXI_BVALID;
    logic S_AXI_BREADY = 1'b0;
    logic ren;
    logic [word_addr_width-1:0] raddr;
    logic [data_width-1:0] rout;
    logic rvalid;
    integer seed = 4;
    int cycle_count = 0;
    int stall_cnt = 0;
    logic long_stall = 1'b0;
    int writes_issued = 0;
    int test_checks = 0;
    int test_errs = 0;

    always #50 S_AXI_ACLK = ~S_AXI_ACLK;
    // unrelated read clock
    always #35 rclk = ~rclk;

    s_axi_lite_async_wmem i_s_axi_lite_async_wmem (.*);

    wmem_checker i_wmem_checker (.*);

    // random bready, or a long hold on every response
    always @(negedge S_AXI_ACLK) begin
        if (!long_stall) begin
            S_AXI_BREADY = ($random(seed) & 3) != 0;
            stall_cnt = 0;
        end else if (S_AXI_BVALID && stall_cnt >= 6) begin
            S_AXI_BREADY = 1'b1;
            stall_cnt = 0;
        end else begin
            S_AXI_BREADY = 1'b0;
            if (S_AXI_BVALID) stall_cnt++;
        end
    end

    always @(posedge S_AXI_ACLK) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, a handshake or response never came", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // each channel opens after its own delay
    task automatic axi_write(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
                             input logic [strb_width-1:0] strb, input int aw_delay,
                             input int w_delay);
        int t;
        logic aw_done;
        logic w_done;
        t = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done)) begin
            @(negedge S_AXI_ACLK);
            S_AXI_AWVALID = !aw_done && t >= aw_delay;
            S_AXI_WVALID = !w_done && t >= w_delay;
            S_AXI_AWADDR = addr;
            S_AXI_WDATA = data;
            S_AXI_WSTRB = strb;
            // readies only move on a rising edge
            aw_done = aw_done || (S_AXI_AWVALID && S_AXI_AWREADY);
            w_done = w_done || (S_AXI_WVALID && S_AXI_WREADY);
            t++;
        end
        writes_issued++;
    endtask

    task automatic random_write(input logic partial, input logic skewed);
        logic [31:0] rnd;
        logic [addr_width-1:0] addr;
        logic [strb_width-1:0] strb;
        int skew;
        rnd = $random(seed);
        addr = rnd[addr_width-1:0];
        strb = partial ? rnd[addr_width +: strb_width] : '1;
        // 2 means both valids together
        skew = skewed ? int'(rnd[23:16]) % 5 : 2;
        rnd = $random(seed);
        axi_write(addr, rnd, strb, skew > 2 ? skew - 2 : 0, skew < 2 ? 2 - skew : 0);
    endtask

    // drop valids, then wait for every B
    task automatic drain_writes();
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID = 1'b0;
        while (i_wmem_checker.b_count < writes_issued) begin
            @(negedge S_AXI_ACLK);
        end
    endtask

    task automatic read_all();
        repeat (3) @(negedge rclk);
        for (int a = 0; a < words; a++) begin
            @(negedge rclk);
            ren = 1'b1;
            raddr = a[word_addr_width-1:0];
        end
        @(negedge rclk);
        ren = 1'b0;
        repeat (2) @(negedge rclk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 i_wmem_checker.pass_count + i_wmem_checker.err_count - test_checks,
                 i_wmem_checker.err_count - test_errs);
        test_checks = i_wmem_checker.pass_count + i_wmem_checker.err_count;
        test_errs = i_wmem_checker.err_count;
    endtask

    initial begin
        S_AXI_ARESETn = 1'b0;
        S_AXI_AWADDR = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA = '0;
        S_AXI_WSTRB = '0;
        S_AXI_WVALID = 1'b0;
        ren = 1'b0;
        raddr = '0;
        repeat (4) @(negedge S_AXI_ACLK);
        S_AXI_ARESETn = 1'b1;
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        read_all();
        report_test(1, "sweep clear");
        for (int k = 0; k < n_writes; k++) random_write(1'b0, 1'b0);
        drain_writes();
        read_all();
        report_test(2, "full strobe");
        for (int k = 0; k < n_writes; k++) random_write(1'b1, 1'b0);
        drain_writes();
        read_all();
        report_test(3, "partial strobe");
        for (int k = 0; k < n_writes; k++) random_write(1'b1, 1'b1);
        drain_writes();
        read_all();
        report_test(4, "aw w skew");
        // every response held for several cycles
        long_stall = 1'b1;
        for (int k = 0; k < n_stall_writes; k++) random_write(1'b1, 1'b1);
        drain_writes();
        long_stall = 1'b0;
        read_all();
        report_test(5, "bready stall");
        // reset again with written words in the ram, the sweep has to clear them
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETn = 1'b0;
        repeat (4) @(negedge S_AXI_ACLK);
        S_AXI_ARESETn = 1'b1;
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        read_all();
        report_test(6, "sweep after writes");
        $display("checks passed %0d, failed %0d", i_wmem_checker.pass_count,
                 i_wmem_checker.err_count);
        if (i_wmem_checker.err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/wmem_pkg.sv
src/clear_sweep_counter.sv
src/write_skid_buffer.sv
src/axi_write_fsm.sv
src/dual_clock_ram.sv
src/s_axi_lite_async_wmem.sv
testbench/wmem_checker.sv
testbench/tb_wmem.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module tb_wmem

sim:
	verilator --binary --timing -f all.f --top-module tb_wmem -o tb_wmem
	./obj_dir/tb_wmem > sim.log
	cat sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
